// File: common/bridge_pkg.sv
// ----------------------------------------------------------
// bridge_pkg
// shared bundles and E-clock timing constants for the
// 68000 to chipset bus bridge
// ----------------------------------------------------------

package bridge_pkg;

  // ----------------------------------------------------------
  // timing constants
  // ----------------------------------------------------------
  localparam int PHASES            = 4;  // 28 MHz cycles per 7 MHz cycle
  localparam int ECLK_PERIODS      = 10; // 7 MHz periods per E clock
  localparam int ECLK_HIGH_FIRST   = 6;  // E high from here to the end
  localparam int VPA_SAMPLE_PERIOD = 3;  // latched VPA sets VMA here
  localparam int DTACK_PERIOD      = 8;  // peripheral DTACK slot
  localparam int VMA_CLEAR_PERIOD  = 9;  // VMA drops here

  // ----------------------------------------------------------
  // bundles
  // ----------------------------------------------------------

  // clock enables, all one clk wide or level
  typedef struct packed {
    logic                    clk7_en;  // 7 MHz rising slot
    logic                    clk7n_en; // 7 MHz falling slot
    logic                    c1;       // quadrature level
    logic                    c3;       // quadrature level
    logic [ECLK_PERIODS-1:0] eclk;     // one-hot E period
  } clk_en_t;

  // 68000 polarity control of the active master
  typedef struct packed {
    logic as_n;
    logic uds_n;
    logic lds_n;
    logic r_w;   // high = read
  } bus_ctrl_t;

  // host port request, active high
  typedef struct packed {
    logic        cs;
    logic        we;
    logic [1:0]  bs;    // [1] upper byte, [0] lower byte
    logic [23:1] adr;
    logic [15:0] wdat;
  } host_req_t;

  // chipset arbitration inputs
  typedef struct packed {
    logic vpa;   // peripheral (CIA) address
    logic dbr;   // data bus request from DMA
    logic dbs;   // data bus slowdown region
    logic xbs;   // cross bridge access
    logic nrdy;  // target not ready
    logic cck;   // colour clock
  } chip_arb_t;

endpackage

// File: src/bus_clock_gen.sv
// ----------------------------------------------------------
// bus_clock_gen
// divides the 28 MHz clock into 7 MHz enables, quadrature
// levels and the one-hot 10 period E clock
// ----------------------------------------------------------

module bus_clock_gen
  import bridge_pkg::*;
(
  input  logic    clk,
  input  logic    _as_and_cs,
  output clk_en_t clk_en,
  output logic    eclk_out
);

  logic [1:0]              phase; // 28 MHz position in the 7 MHz cycle
  logic [ECLK_PERIODS-1:0] eclk;  // one-hot E period ring

  // ----------------------------------------------------------
  // phase counter
  // ----------------------------------------------------------
  always_ff @(posedge clk or posedge _as_and_cs) begin
    if (_as_and_cs) begin
      phase <= '0;
    end else if (phase == 2'(PHASES - 1)) begin
      phase <= '0; // wrap
    end else begin
      phase <= phase + 2'd1;
    end
  end

  // enables decoded straight from the count
  assign clk_en.clk7n_en = (phase == 2'd1);
  assign clk_en.clk7_en  = (phase == 2'd3);
  assign clk_en.c1       = (phase == 2'd1) || (phase == 2'd2);
  assign clk_en.c3       = (phase == 2'd2) || (phase == 2'd3);

  // ----------------------------------------------------------
  // E clock ring, one step per 7 MHz cycle
  // ----------------------------------------------------------
  always_ff @(posedge clk or posedge _as_and_cs) begin
    if (_as_and_cs) begin
      eclk <= ECLK_PERIODS'(1); // period 0
    end else if (clk_en.clk7_en) begin
      eclk <= {eclk[ECLK_PERIODS-2:0], eclk[ECLK_PERIODS-1]}; // rotate
    end
  end

  assign clk_en.eclk = eclk;

  // E is high in the last four periods
  assign eclk_out = |eclk[ECLK_PERIODS-1:ECLK_HIGH_FIRST];

endmodule

// File: bridge/bus_source_select.sv
// ----------------------------------------------------------
// bus_source_select
// picks CPU or host as bus master, tracks halt and latches
// the control strobes at 7 MHz and 28 MHz
// ----------------------------------------------------------

module bus_source_select
  import bridge_pkg::*;
(
  input  logic        clk,
  input  clk_en_t     clk_en,
  input  bus_ctrl_t   cpu_ctrl,
  input  logic        cpu_halt,
  input  host_req_t   host,
  input  logic [23:1] address,
  input  logic [15:0] cpudatain,
  output bus_ctrl_t   bus_ctrl,
  output logic        as_n_fast,
  output logic        as_idle,
  output logic [23:1] address_out,
  output logic [15:0] data_out
);

  logic      halt;       // host owns the bus
  bus_ctrl_t host_ctrl;  // host request in 68000 polarity
  bus_ctrl_t sel_ctrl;   // current master, unlatched
  logic      as_n_28m;   // first stage of the fast strobe

  // ----------------------------------------------------------
  // halt tracking
  // ----------------------------------------------------------
  // only follows the request between CPU cycles
  always_ff @(posedge clk) begin
    if (clk_en.clk7_en && cpu_ctrl.as_n) begin
      halt <= cpu_halt;
    end
  end

  // host strobes are active high, flip them
  assign host_ctrl.as_n  = ~host.cs;
  assign host_ctrl.uds_n = ~host.bs[1];
  assign host_ctrl.lds_n = ~host.bs[0];
  assign host_ctrl.r_w   = ~host.we;

  assign sel_ctrl = halt ? host_ctrl : cpu_ctrl;

  // raw strobe of the master, resets DTACK
  assign as_idle = sel_ctrl.as_n;

  // ----------------------------------------------------------
  // control latches
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (clk_en.clk7_en) begin
      bus_ctrl.r_w  <= sel_ctrl.r_w;
      bus_ctrl.as_n <= sel_ctrl.as_n;
    end
  end

  // data strobes at full rate
  always_ff @(posedge clk) begin
    bus_ctrl.uds_n <= sel_ctrl.uds_n;
    bus_ctrl.lds_n <= sel_ctrl.lds_n;
  end

  // turbo strobe, resampled then aligned to 7 MHz
  always_ff @(posedge clk) begin
    as_n_28m <= sel_ctrl.as_n;
    if (clk_en.clk7_en) begin
      as_n_fast <= as_n_28m;
    end
  end

  // ----------------------------------------------------------
  // address and write data mux
  // ----------------------------------------------------------
  assign address_out = halt ? host.adr  : address;
  assign data_out    = halt ? host.wdat : cpudatain;

endmodule

// File: bridge/transfer_control.sv
// ----------------------------------------------------------
// transfer_control
// VPA/VMA E-clock sequencing, DTACK generation, turbo select
// and the synchronous read, write and slowdown strobes
// ----------------------------------------------------------

module transfer_control
  import bridge_pkg::*;
(
  input  logic      clk,
  input  clk_en_t   clk_en,
  input  chip_arb_t arb,
  input  logic      vpa_raw,
  input  bus_ctrl_t bus_ctrl,
  input  logic      as_n_fast,
  input  logic      as_idle,
  input  logic      cpu_speed,
  output logic      dtack_n,
  output logic      turbo,
  output logic      enable,
  output logic      rd,
  output logic      hwr,
  output logic      lwr,
  output logic      bls
);

  logic lvpa;      // VPA sampled at 7 MHz
  logic vma;       // valid memory address, E synchronised
  logic l_dtack;   // DTACK seen by the bus, active low
  logic ta_go;     // acknowledge condition
  logic normal_go; // plain chipset access may finish
  logic periph_go; // peripheral slot reached

  // ----------------------------------------------------------
  // speed mode, only between accesses
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (clk_en.clk7_en && as_idle) begin
      turbo <= cpu_speed;
    end
  end

  // ----------------------------------------------------------
  // VPA / VMA
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (clk_en.clk7_en) begin
      lvpa <= arb.vpa;
    end
  end

  always_ff @(posedge clk) begin
    if (clk_en.clk7_en) begin
      if (clk_en.eclk[VMA_CLEAR_PERIOD]) begin
        vma <= 1'b0; // end of E cycle
      end else if (clk_en.eclk[VPA_SAMPLE_PERIOD] && lvpa) begin
        vma <= 1'b1;
      end
    end
  end

  // ----------------------------------------------------------
  // DTACK
  // ----------------------------------------------------------
  assign normal_go = ~vpa_raw && ~(arb.dbr && arb.dbs);
  assign periph_go = vpa_raw && vma && clk_en.eclk[DTACK_PERIOD];
  assign ta_go     = ~bus_ctrl.as_n && arb.cck && (normal_go || periph_go) && ~arb.nrdy;

  // released at once when the strobe goes high
  always_ff @(posedge clk or posedge as_idle) begin
    if (as_idle) begin
      dtack_n <= 1'b1;
    end else if (clk_en.clk7n_en && ta_go) begin
      dtack_n <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (clk_en.clk7_en) begin
      l_dtack <= dtack_n;
    end
  end

  // ----------------------------------------------------------
  // bus strobes
  // ----------------------------------------------------------
  // normal mode waits for DTACK, turbo runs ahead of it
  assign enable = (~bus_ctrl.as_n & ~l_dtack & ~arb.cck & ~turbo)
                | (~as_n_fast & l_dtack & ~(arb.dbr & arb.xbs) & ~arb.nrdy & turbo);

  assign rd  = enable & bus_ctrl.r_w;
  assign hwr = enable & ~bus_ctrl.r_w & ~bus_ctrl.uds_n; // upper byte
  assign lwr = enable & ~bus_ctrl.r_w & ~bus_ctrl.lds_n; // lower byte

  // CPU is waiting on a slow region, ask the blitter to yield
  assign bls = arb.dbs & ~bus_ctrl.as_n & l_dtack;

endmodule

// File: bridge/read_latch.sv
// ----------------------------------------------------------
// read_latch
// holds chipset read data for the CPU and the host port
// ----------------------------------------------------------

module read_latch
  import bridge_pkg::*;
(
  input  logic        clk,
  input  clk_en_t     clk_en,
  input  logic        enable,
  input  logic [15:0] data_in,
  output logic [15:0] cpu_data,
  output logic [15:0] host_rdat
);

  logic        capture; // phase 3 of an enabled cycle
  logic [15:0] ldata;   // held read word

  // c1 low with c3 high marks the data valid slot
  assign capture = ~clk_en.c1 & clk_en.c3 & enable;

  always_ff @(posedge clk) begin
    if (capture) begin
      ldata <= data_in;
    end
  end

  // ----------------------------------------------------------
  // both masters see the same word
  // ----------------------------------------------------------
  assign cpu_data  = ldata;
  assign host_rdat = ldata;

endmodule

// File: src/m68k_bridge_top.sv
// ----------------------------------------------------------
// m68k_bridge_top
// 68000 CPU to synchronous chipset bus bridge with host port
// ----------------------------------------------------------

module m68k_bridge_top
  import bridge_pkg::*;
(
  input  logic        clk,
  input  logic        _as_and_cs,
  // CPU bus
  input  logic        _as,
  input  logic        _uds,
  input  logic        _lds,
  input  logic        r_w,
  input  logic [23:1] address,
  input  logic [15:0] cpudatain,
  output logic        _dtack,
  output logic [15:0] data,
  // chipset bus
  input  chip_arb_t   arb,
  input  logic [15:0] data_in,
  output logic [23:1] address_out,
  output logic [15:0] data_out,
  output logic        rd,
  output logic        hwr,
  output logic        lwr,
  output logic        bls,
  // speed and host port
  input  logic        cpu_speed,
  output logic        turbo,
  input  logic        cpu_halt,
  input  host_req_t   host,
  output logic [15:0] host_rdat,
  output logic        host_ack,
  output logic        eclk_out
);

  clk_en_t   clk_en;
  bus_ctrl_t cpu_ctrl;  // CPU strobes bundled
  bus_ctrl_t bus_ctrl;  // latched strobes of the master
  logic      as_n_fast;
  logic      as_idle;
  logic      enable;

  assign cpu_ctrl = '{as_n: _as, uds_n: _uds, lds_n: _lds, r_w: r_w};

  // ack seen by the host is the same flop
  assign host_ack = ~_dtack;

  // ----------------------------------------------------------
  // instances
  // ----------------------------------------------------------
  bus_clock_gen u_clk_gen (
    .clk        (clk),
    ._as_and_cs (_as_and_cs),
    .clk_en     (clk_en),
    .eclk_out   (eclk_out)
  );

  bus_source_select u_source (
    .clk         (clk),
    .clk_en      (clk_en),
    .cpu_ctrl    (cpu_ctrl),
    .cpu_halt    (cpu_halt),
    .host        (host),
    .address     (address),
    .cpudatain   (cpudatain),
    .bus_ctrl    (bus_ctrl),
    .as_n_fast   (as_n_fast),
    .as_idle     (as_idle),
    .address_out (address_out),
    .data_out    (data_out)
  );

  transfer_control u_xfer (
    .clk       (clk),
    .clk_en    (clk_en),
    .arb       (arb),
    .vpa_raw   (arb.vpa),
    .bus_ctrl  (bus_ctrl),
    .as_n_fast (as_n_fast),
    .as_idle   (as_idle),
    .cpu_speed (cpu_speed),
    .dtack_n   (_dtack),
    .turbo     (turbo),
    .enable    (enable),
    .rd        (rd),
    .hwr       (hwr),
    .lwr       (lwr),
    .bls       (bls)
  );

  read_latch u_rdata (
    .clk       (clk),
    .clk_en    (clk_en),
    .enable    (enable),
    .data_in   (data_in),
    .cpu_data  (data),
    .host_rdat (host_rdat)
  );

endmodule

// File: dv/bridge_tb_table.svh
// ----------------------------------------------------------
// bridge_tb access table
// one row per bus access with its expected bus response
// ----------------------------------------------------------

`ifndef BRIDGE_TB_TABLE_SVH
`define BRIDGE_TB_TABLE_SVH

localparam int NUM_ROWS = 13;

// one bus access and what the bridge should do with it
typedef struct packed {
  logic        host;    // 1 = host port under halt, 0 = CPU
  logic        rw;      // 1 = read
  logic        ub;      // upper byte active
  logic        lb;      // lower byte active
  logic [23:1] addr;
  logic [15:0] wdat;
  logic [15:0] rdat;    // chipset word returned on a read
  logic        vpa;
  logic        dbr;
  logic        dbs;
  logic        nrdy;
  logic        speed;   // cpu_speed, 1 = turbo
  logic [7:0]  limit;   // clocks allowed for DTACK
  logic        ack;     // DTACK expected within limit
  logic        exp_rd;
  logic        exp_hwr;
  logic        exp_lwr;
  logic        exp_bls;
} access_row_t;

access_row_t table_rows [NUM_ROWS];

// columns: host rw ub lb | addr wdat rdat | vpa dbr dbs nrdy speed | limit
//          | ack rd hwr lwr bls
task automatic load_access_table();
  // plain CPU reads and writes
  table_rows[0]  = '{1'b0, 1'b1, 1'b1, 1'b1, 23'h000100, 16'h0000, 16'hA5C3,
                     1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 8'd14, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0};
  table_rows[1]  = '{1'b0, 1'b0, 1'b1, 1'b1, 23'h0F0040, 16'h1234, 16'h0000,
                     1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 8'd14, 1'b1, 1'b0, 1'b1, 1'b1, 1'b0};
  table_rows[2]  = '{1'b0, 1'b0, 1'b1, 1'b0, 23'h0F0042, 16'hBE00, 16'h0000,
                     1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 8'd14, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0};
  table_rows[3]  = '{1'b0, 1'b0, 1'b0, 1'b1, 23'h0F0043, 16'h00EF, 16'h0000,
                     1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 8'd14, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0};
  // hold-off, target not ready then DMA conflict
  table_rows[4]  = '{1'b0, 1'b1, 1'b1, 1'b1, 23'h000300, 16'h0000, 16'h1111,
                     1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 8'd40, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0};
  table_rows[5]  = '{1'b0, 1'b0, 1'b1, 1'b1, 23'h000304, 16'h2222, 16'h0000,
                     1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 8'd40, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1};
  // peripheral read on the E clock
  table_rows[6]  = '{1'b0, 1'b1, 1'b1, 1'b1, 23'h5FE001, 16'h0000, 16'h00BF,
                     1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 8'd100, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0};
  // host port while the CPU is halted
  table_rows[7]  = '{1'b1, 1'b1, 1'b1, 1'b1, 23'h010200, 16'h0000, 16'h5A5A,
                     1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 8'd14, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0};
  table_rows[8]  = '{1'b1, 1'b0, 1'b1, 1'b1, 23'h010204, 16'hC0DE, 16'h0000,
                     1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 8'd14, 1'b1, 1'b0, 1'b1, 1'b1, 1'b0};
  // halt cleared, CPU address back on the bus
  table_rows[9]  = '{1'b0, 1'b1, 1'b1, 1'b1, 23'h000200, 16'h0000, 16'h3C3C,
                     1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 8'd14, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0};
  // turbo accesses
  table_rows[10] = '{1'b0, 1'b0, 1'b1, 1'b1, 23'h0F0080, 16'h4D2B, 16'h0000,
                     1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 8'd14, 1'b1, 1'b0, 1'b1, 1'b1, 1'b0};
  table_rows[11] = '{1'b0, 1'b1, 1'b1, 1'b1, 23'h0F0084, 16'h0000, 16'h7E81,
                     1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 8'd14, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0};
  table_rows[12] = '{1'b0, 1'b0, 1'b0, 1'b1, 23'h0F0089, 16'h0099, 16'h0000,
                     1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 8'd14, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0};
endtask

`endif

// File: dv/bridge_tb.sv
// ----------------------------------------------------------
// bridge_tb
// table driven testbench for the 68000 chipset bus bridge
// ----------------------------------------------------------

module bridge_tb
  import bridge_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  `include "bridge_tb_table.svh"

  localparam int  ECLK_CLOCKS = 40;                               // 10 periods of 4 clocks
  localparam time WATCHDOG_NS = (NUM_ROWS + 2) * 40 * ECLK_CLOCKS * 20;

  logic        clk = 1'b0;
  logic        _as_and_cs;
  logic        _as, _uds, _lds, r_w;
  logic [23:1] address;
  logic [15:0] cpudatain, data_in, data, data_out, host_rdat;
  logic        _dtack, rd, hwr, lwr, bls, turbo, host_ack, eclk_out;
  logic        cpu_speed, cpu_halt;
  logic [23:1] address_out;
  chip_arb_t   arb;
  host_req_t   host;

  logic [15:0] lfsr = 16'd17238;                                  // filler source
  int          edge_cnt = 0;
  int          e_high_cnt = 0;                                    // negedges since E rose
  logic        watching = 1'b0;
  logic        seen_rd, seen_hwr, seen_lwr, seen_bls, ack_seen, ack_eclk;
  logic        seen_early;                                        // strobe ahead of DTACK
  int          ack_ecnt;
  int          test_errors, total_errors = 0, failed_tests = 0, num_tests = 0;

  m68k_bridge_top uut (.*);

  always #10 clk = ~clk;

  // colour clock, one toggle per 7 MHz cycle from reset release
  always @(posedge clk) begin
    if (!_as_and_cs) begin
      edge_cnt = edge_cnt + 1;
      if (edge_cnt % 4 == 0) begin
        #2;
        arb.cck = ~arb.cck;
      end
    end
  end

  // ----------------------------------------------------------
  // bus monitor, sampled mid cycle
  // ----------------------------------------------------------
  always @(negedge clk) begin
    e_high_cnt = eclk_out ? e_high_cnt + 1 : 0;
    if (watching) begin
      seen_rd  = seen_rd | rd;
      seen_hwr = seen_hwr | hwr;
      seen_lwr = seen_lwr | lwr;
      seen_bls = seen_bls | bls;
      if ((rd | hwr | lwr) && !ack_seen) begin
        seen_early = 1'b1;                                        // only turbo runs ahead
      end
      if (!_dtack && !ack_seen) begin
        ack_seen = 1'b1;                                          // first DTACK low
        ack_ecnt = e_high_cnt;
        ack_eclk = eclk_out;
      end
    end
  end

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];                           // x^16+x^14+x^13+x^11+1
    return {s[14:0], fb};
  endfunction

  // one LFSR step per bit of the word
  task automatic filler_word(output logic [15:0] w);
    w = '0;
    for (int i = 0; i < 16; i++) begin
      lfsr = lfsr_next(lfsr);
      w = {w[14:0], lfsr[0]};
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("ERROR at %0t: %s expected %0h got %0h", $time, name, exp, got);
      test_errors++;
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    assert (cond) else begin
      $display("at %0t: %s", $time, what);
      test_errors++;
    end
  endtask

  task automatic close_test(input string what);
    num_tests++;
    total_errors += test_errors;
    if (test_errors != 0) failed_tests++;
    $display("test %0d %s: %s", num_tests, what, (test_errors == 0) ? "ok" : "failed");
    test_errors = 0;
  endtask

  // ----------------------------------------------------------
  // one table row
  // ----------------------------------------------------------
  task automatic run_access(input int idx);
    access_row_t r;
    logic [15:0] fill;
    int          n;
    r = table_rows[idx];
    filler_word(fill);
    @(posedge clk);
    #2;
    cpu_halt  = r.host;                                           // settles while idle
    cpu_speed = r.speed;
    arb.vpa   = r.vpa;
    arb.dbr   = r.dbr;
    arb.dbs   = r.dbs;
    arb.nrdy  = r.nrdy;
    data_in   = r.rdat;
    repeat (8) @(posedge clk);
    #2;
    seen_rd    = 1'b0;
    seen_hwr   = 1'b0;
    seen_lwr   = 1'b0;
    seen_bls   = 1'b0;
    seen_early = 1'b0;
    ack_seen   = 1'b0;
    if (r.host) begin
      host.adr  = r.addr;
      host.wdat = r.wdat;
      host.we   = ~r.rw;
      host.bs   = {r.ub, r.lb};
      host.cs   = 1'b1;
    end else begin
      address   = r.addr;
      cpudatain = r.rw ? fill : r.wdat;
      r_w       = r.rw;
      _uds      = ~r.ub;
      _lds      = ~r.lb;
      _as       = 1'b0;
    end
    watching = 1'b1;
    #1;
    check_value("address_out", 32'(address_out), 32'(r.addr));
    if (!r.rw) check_value("data_out", 32'(data_out), 32'(r.wdat));
    n = 0;
    while (!ack_seen && n < int'(r.limit)) begin
      @(posedge clk);
      n++;
    end
    if (ack_seen) repeat (12) @(posedge clk);                     // let the strobes run
    #1;
    check_value("dtack", 32'(ack_seen), 32'(r.ack));
    check_value("rd", 32'(seen_rd), 32'(r.exp_rd));
    check_value("hwr", 32'(seen_hwr), 32'(r.exp_hwr));
    check_value("lwr", 32'(seen_lwr), 32'(r.exp_lwr));
    check_value("bls", 32'(seen_bls), 32'(r.exp_bls));
    check_value("turbo", 32'(turbo), 32'(r.speed));
    check_value("strobe_before_dtack", 32'(seen_early), 32'(r.speed));
    if (r.host) check_value("host_ack", 32'(host_ack), 32'(r.ack));
    if (r.rw && r.ack) begin
      if (r.host) check_value("host_rdat", 32'(host_rdat), 32'(r.rdat));
      else check_value("data", 32'(data), 32'(r.rdat));
    end
    if (r.vpa && ack_seen)
      check_true(ack_eclk && ack_ecnt > 8,
                 "peripheral DTACK came before the third E high period");
    watching = 1'b0;
    #1;
    host.cs = 1'b0;
    _as     = 1'b1;
    data_in = fill;
    #1;
    check_value("dtack_release", 32'(_dtack), 32'd1);             // asynchronous release
    close_test($sformatf("row %0d %s", idx, r.host ? "host" : "cpu"));
  endtask

  // ----------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------
  initial begin
    $timeformat(-9, 1, " ns", 0);
    _as_and_cs = 1'b1;
    _as = 1'b1;
    _uds = 1'b1;
    _lds = 1'b1;
    r_w = 1'b1;
    address = '0;
    cpudatain = '0;
    data_in = '0;
    arb = '0;
    arb.cck = 1'b1;
    host = '0;
    cpu_speed = 1'b0;
    cpu_halt = 1'b0;
    test_errors = 0;
    load_access_table();
    repeat (16) @(posedge clk);
    #2;
    _as_and_cs = 1'b0;
    // E clock, 24 low then 16 high
    for (int i = 0; i < 3 * ECLK_CLOCKS; i++) begin
      @(negedge clk);
      check_value("eclk_out", 32'(eclk_out), 32'((i % ECLK_CLOCKS) >= 24));
    end
    close_test("eclk shape");
    for (int i = 0; i < NUM_ROWS; i++) run_access(i);
    // turbo may only change between accesses
    @(posedge clk);
    #2;
    cpu_speed = 1'b0;
    cpu_halt = 1'b0;
    arb.vpa = 1'b0;
    arb.dbr = 1'b0;
    arb.dbs = 1'b0;
    repeat (8) @(posedge clk);
    #2;
    r_w = 1'b1;
    _uds = 1'b0;
    _lds = 1'b0;
    _as = 1'b0;
    repeat (4) @(posedge clk);
    #2;
    cpu_speed = 1'b1;
    repeat (20) @(posedge clk);
    #1;
    check_value("turbo", 32'(turbo), 32'd0);
    @(posedge clk);
    #2;
    _as = 1'b1;
    repeat (8) @(posedge clk);
    #1;
    check_value("turbo", 32'(turbo), 32'd1);
    close_test("turbo hold");
    $display("tests %0d, failed %0d, errors %0d", num_tests, failed_tests, total_errors);
    if (total_errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("watchdog timeout, the run did not finish in time");
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

// File: vlog.f
+incdir+dv
common/bridge_pkg.sv
src/bus_clock_gen.sv
bridge/bus_source_select.sv
bridge/transfer_control.sv
bridge/read_latch.sv
src/m68k_bridge_top.sv
dv/bridge_tb.sv

// File: Makefile
# Verilator build and run for the bridge testbench

TOP       ?= bridge_tb
FLIST     ?= vlog.f
LOG       ?= sim.log
BUILD     ?= obj_dir
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "  help   this list"
	@echo "variables: TOP FLIST LOG BUILD VERILATOR VFLAGS"

$(BUILD)/V$(TOP): $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD)

test: $(BUILD)/V$(TOP)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
